// ==== source/spi_fpu_defines.svh ====
`ifndef SPI_FPU_DEFINES_SVH
`define SPI_FPU_DEFINES_SVH

// Register file shape.
`define FPU_REG_COUNT 4
`define FPU_REG_ID_WIDTH 2

// Flip-flops per input synchronizer.
`define SPI_SYNC_STAGES 2

// Clocks from adder start to done.
`define ADDER_STAGES 4

`endif

// ==== source/spi_fpu_pkg.sv ====
package spi_fpu_pkg;

	typedef enum logic [1:0] {
		command_write_register = 2'd0,
		command_add_registers  = 2'd1,
		command_read_register  = 2'd2,
		command_reserved       = 2'd3
	} fpu_command_t;

	typedef enum logic [2:0] {
		state_idle,
		state_read_command,
		state_read_target,
		state_transfer,
		state_read_operands,
		state_wait_sum,
		state_wait_end
	} controller_state_t;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} float_t;

	// One byte between the link and the controller.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} spi_byte_t;

endpackage

// ==== source/spi_link.sv ====
`timescale 1ns/1ps
`include "spi_fpu_defines.svh"

module spi_link (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   spi_clock,
	input  logic                   spi_in,
	output logic                   spi_out,
	input  logic                   spi_not_chip_select,
	output spi_fpu_pkg::spi_byte_t rx_byte,
	input  spi_fpu_pkg::spi_byte_t tx_byte,
	output logic                   tx_taken,
	output logic                   active
);
	import spi_fpu_pkg::*;

	logic [`SPI_SYNC_STAGES-1:0] clock_sync;
	logic [`SPI_SYNC_STAGES-1:0] data_sync;
	logic [`SPI_SYNC_STAGES-1:0] select_sync;
	logic                        clock_previous;
	logic                        select_previous;
	logic                        clock_rise;
	logic                        clock_fall;
	logic                        select_fall;
	logic [7:0]                  rx_shift;
	logic [2:0]                  bit_count;
	logic [7:0]                  tx_shift;
	logic                        load_pending;
	spi_byte_t                   completed;

	assign active      = ~select_sync[`SPI_SYNC_STAGES-1];
	assign clock_rise  = clock_sync[`SPI_SYNC_STAGES-1] & ~clock_previous;
	assign clock_fall  = ~clock_sync[`SPI_SYNC_STAGES-1] & clock_previous;
	assign select_fall = select_previous & active;
	assign spi_out     = active & tx_shift[7]; // MSB first.

	assign completed.valid = active & clock_rise & (bit_count == 3'd7);
	assign completed.data  = {rx_shift[6:0], data_sync[`SPI_SYNC_STAGES-1]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			clock_sync      <= '0;
			data_sync       <= '0;
			select_sync     <= '1; // Deselected.
			clock_previous  <= 1'b0;
			select_previous <= 1'b1;
		end
		else
		begin
			clock_sync      <= {clock_sync[`SPI_SYNC_STAGES-2:0], spi_clock};
			data_sync       <= {data_sync[`SPI_SYNC_STAGES-2:0], spi_in};
			select_sync     <= {select_sync[`SPI_SYNC_STAGES-2:0], spi_not_chip_select};
			clock_previous  <= clock_sync[`SPI_SYNC_STAGES-1];
			select_previous <= select_sync[`SPI_SYNC_STAGES-1];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bit_count     <= 3'd0;
			rx_byte.valid <= 1'b0;
		end
		else
		begin
			rx_byte <= completed;
			if (!active)
				bit_count <= 3'd0;
			else if (clock_rise)
			begin
				rx_shift  <= completed.data;
				bit_count <= bit_count + 3'd1;
			end
		end
	end

	// Next byte goes out on the falling edge after the eighth rising edge.
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tx_shift     <= 8'h00;
			tx_taken     <= 1'b0;
			load_pending <= 1'b0;
		end
		else
		begin
			tx_taken <= 1'b0;
			if (!active)
				load_pending <= 1'b0;
			else if (select_fall || (clock_fall && load_pending))
			begin
				tx_shift     <= tx_byte.valid ? tx_byte.data : 8'h00;
				tx_taken     <= tx_byte.valid;
				load_pending <= 1'b0;
			end
			else if (clock_fall)
				tx_shift <= {tx_shift[6:0], 1'b0};
			else if (completed.valid)
				load_pending <= 1'b1;
		end
	end

endmodule

// ==== source/float_adder.sv ====
`timescale 1ns/1ps
`include "spi_fpu_defines.svh"

module float_adder (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  spi_fpu_pkg::float_t operand_a,
	input  spi_fpu_pkg::float_t operand_b,
	output spi_fpu_pkg::float_t sum,
	output logic                done
);
	import spi_fpu_pkg::*;

	logic [`ADDER_STAGES-1:0] valid_pipe;

	float_t             flushed_a;
	float_t             flushed_b;
	float_t             larger;
	float_t             smaller;
	logic               s1_sign;
	logic               s1_subtract;
	logic [7:0]         s1_exponent;
	logic [7:0]         s1_difference;
	logic [23:0]        s1_big;
	logic [23:0]        s1_small;

	logic [26:0]        small_extended;
	logic [26:0]        shifted;
	logic               lost;
	logic               s2_sign;
	logic               s2_subtract;
	logic [7:0]         s2_exponent;
	logic [26:0]        s2_big;
	logic [26:0]        s2_small;

	logic               s3_sign;
	logic               s3_subtract;
	logic [7:0]         s3_exponent;
	logic [27:0]        s3_total;

	logic [4:0]         zero_count;
	logic [27:0]        normalized;
	logic signed [9:0]  exponent_wide;
	float_t             result;

	function automatic logic [4:0] leading_zeros(input logic [27:0] value);
		logic [4:0] count;
		logic       found;
		count = 5'd28;
		found = 1'b0;
		for (int index = 27; index >= 0; index--)
		begin
			if (!found && value[index])
			begin
				count = 5'(27 - index);
				found = 1'b1;
			end
		end
		return count;
	endfunction

	assign done = valid_pipe[`ADDER_STAGES-1];

	always_comb
	begin
		flushed_a = operand_a;
		flushed_b = operand_b;
		if (operand_a.exponent == 8'd0)
			flushed_a.mantissa = '0; // Denormal to signed zero.
		if (operand_b.exponent == 8'd0)
			flushed_b.mantissa = '0;
		if ({flushed_a.exponent, flushed_a.mantissa} >= {flushed_b.exponent, flushed_b.mantissa})
		begin
			larger  = flushed_a;
			smaller = flushed_b;
		end
		else
		begin
			larger  = flushed_b;
			smaller = flushed_a;
		end
	end

	// Three extra bits below the mantissa, the last one sticky.
	assign small_extended = {s1_small, 3'b000};
	assign shifted        = small_extended >> s1_difference;
	assign lost           = (small_extended & ~({27{1'b1}} << s1_difference)) != 27'd0;

	always_comb
	begin
		zero_count    = leading_zeros(s3_total);
		normalized    = s3_total << zero_count;
		exponent_wide = $signed({2'b00, s3_exponent}) + 10'sd1 - $signed({5'b00000, zero_count});
		result.sign     = s3_sign;
		result.exponent = exponent_wide[7:0];
		result.mantissa = normalized[26:4]; // Truncate.
		if (s3_total == 28'd0)
		begin
			result      = '0;
			result.sign = s3_sign & ~s3_subtract; // x - x is +0.
		end
		else if (exponent_wide <= 0)
		begin
			result.exponent = 8'h00;
			result.mantissa = '0;
		end
		else if (exponent_wide >= 255)
		begin
			result.exponent = 8'hff; // Infinity.
			result.mantissa = '0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[`ADDER_STAGES-2:0], start};
	end

	always_ff @(posedge clock)
	begin
		s1_sign       <= larger.sign;
		s1_subtract   <= larger.sign ^ smaller.sign;
		s1_exponent   <= larger.exponent;
		s1_difference <= larger.exponent - smaller.exponent;
		s1_big        <= {larger.exponent != 8'd0, larger.mantissa};
		s1_small      <= {smaller.exponent != 8'd0, smaller.mantissa};

		s2_sign     <= s1_sign;
		s2_subtract <= s1_subtract;
		s2_exponent <= s1_exponent;
		s2_big      <= {s1_big, 3'b000};
		s2_small    <= {shifted[26:1], shifted[0] | lost};

		s3_sign     <= s2_sign;
		s3_subtract <= s2_subtract;
		s3_exponent <= s2_exponent;
		s3_total    <= s2_subtract ? {1'b0, s2_big} - {1'b0, s2_small}
		                           : {1'b0, s2_big} + {1'b0, s2_small};

		sum <= result;
	end

endmodule

// ==== source/fpu_controller.sv ====
`timescale 1ns/1ps
`include "spi_fpu_defines.svh"

module fpu_controller (
	input  logic                   clock,
	input  logic                   reset,
	input  spi_fpu_pkg::spi_byte_t rx_byte,
	input  logic                   active,
	output spi_fpu_pkg::spi_byte_t tx_byte,
	input  logic                   tx_taken,
	output logic                   start,
	output spi_fpu_pkg::float_t    operand_a,
	output spi_fpu_pkg::float_t    operand_b,
	input  spi_fpu_pkg::float_t    sum,
	input  logic                   done
);
	import spi_fpu_pkg::*;

	float_t                       float_registers [`FPU_REG_COUNT];
	controller_state_t            state;
	fpu_command_t                 command;
	logic [1:0]                   byte_counter; // Byte within a word, LSB first.
	logic [`FPU_REG_ID_WIDTH-1:0] target_id;
	logic [`FPU_REG_ID_WIDTH-1:0] source_a_id;
	logic [`FPU_REG_ID_WIDTH-1:0] source_b_id;
	logic                         last_byte;

	assign last_byte     = byte_counter == 2'd3;
	assign operand_a     = float_registers[source_a_id];
	assign operand_b     = float_registers[source_b_id];
	assign tx_byte.valid = (state == state_transfer) && (command == command_read_register);
	assign tx_byte.data  = float_registers[target_id][8 * byte_counter +: 8];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state        <= state_idle;
			command      <= command_write_register;
			byte_counter <= 2'd0;
			target_id    <= '0;
			source_a_id  <= '0;
			source_b_id  <= '0;
			start        <= 1'b0;
			for (int index = 0; index < `FPU_REG_COUNT; index++)
				float_registers[index] <= '0;
		end
		else
		begin
			start <= 1'b0;
			if (!active)
				state <= state_idle; // Chip select high ends any command.
			else
			begin
				case (state)
					state_idle:
						state <= state_read_command;
					state_read_command:
						if (rx_byte.valid)
						begin
							command      <= fpu_command_t'(rx_byte.data[1:0]);
							byte_counter <= 2'd0;
							case (fpu_command_t'(rx_byte.data[1:0]))
								command_write_register: state <= state_read_target;
								command_read_register:  state <= state_read_target;
								command_add_registers:  state <= state_read_operands;
								default:                state <= state_wait_end;
							endcase
						end
					state_read_target:
						if (rx_byte.valid)
						begin
							target_id <= rx_byte.data[`FPU_REG_ID_WIDTH-1:0];
							state     <= state_transfer;
						end
					state_transfer:
						if (command == command_write_register)
						begin
							if (rx_byte.valid)
							begin
								float_registers[target_id][8 * byte_counter +: 8] <= rx_byte.data;
								byte_counter <= byte_counter + 2'd1;
								if (last_byte)
									state <= state_wait_end;
							end
						end
						else if (tx_taken)
						begin
							byte_counter <= byte_counter + 2'd1;
							if (last_byte)
								state <= state_wait_end;
						end
					state_read_operands:
						if (rx_byte.valid)
						begin
							byte_counter <= byte_counter + 2'd1;
							case (byte_counter)
								2'd0: source_a_id <= rx_byte.data[`FPU_REG_ID_WIDTH-1:0];
								2'd1: source_b_id <= rx_byte.data[`FPU_REG_ID_WIDTH-1:0];
								default:
								begin
									target_id <= rx_byte.data[`FPU_REG_ID_WIDTH-1:0];
									start     <= 1'b1;
									state     <= state_wait_sum;
								end
							endcase
						end
					state_wait_sum:
						if (done)
						begin
							float_registers[target_id] <= sum;
							state <= state_wait_end;
						end
					state_wait_end:
						state <= state_wait_end; // Extra bytes are dropped.
					default:
						state <= state_idle;
				endcase
			end
		end
	end

endmodule

// ==== source/spi_fpu.sv ====
`timescale 1ns/1ps

module spi_fpu (
	input  logic clock,
	input  logic reset,
	input  logic spi_clock,
	input  logic spi_in,
	output logic spi_out,
	input  logic spi_not_chip_select
);
	spi_fpu_pkg::spi_byte_t rx_byte;
	spi_fpu_pkg::spi_byte_t tx_byte;
	spi_fpu_pkg::float_t    operand_a;
	spi_fpu_pkg::float_t    operand_b;
	spi_fpu_pkg::float_t    sum;
	logic                   tx_taken;
	logic                   active;
	logic                   start;
	logic                   done;

	spi_link link0 (
		.clock(clock), .reset(reset),
		.spi_clock(spi_clock), .spi_in(spi_in), .spi_out(spi_out),
		.spi_not_chip_select(spi_not_chip_select),
		.rx_byte(rx_byte), .tx_byte(tx_byte), .tx_taken(tx_taken), .active(active)
	);

	fpu_controller controller0 (
		.clock(clock), .reset(reset),
		.rx_byte(rx_byte), .active(active), .tx_byte(tx_byte), .tx_taken(tx_taken),
		.start(start), .operand_a(operand_a), .operand_b(operand_b),
		.sum(sum), .done(done)
	);

	float_adder adder0 (
		.clock(clock), .reset(reset),
		.start(start), .operand_a(operand_a), .operand_b(operand_b),
		.sum(sum), .done(done)
	);

endmodule

// ==== tb/spi_fpu_tb.sv ====
`timescale 1ns/1ps

module spi_fpu_tb;

	logic        clock;
	logic        reset;
	logic        spi_clock;
	logic        spi_in;
	logic        spi_out;
	logic        spi_not_chip_select;

	integer      seed;
	logic [31:0] model [4];
	logic [31:0] pattern;
	logic [31:0] received;
	int          value_a;
	int          value_b;
	int          power;

	spi_fpu dut0 (
		.clock(clock),
		.reset(reset),
		.spi_clock(spi_clock),
		.spi_in(spi_in),
		.spi_out(spi_out),
		.spi_not_chip_select(spi_not_chip_select)
	);

	always #50 clock = ~clock;

	// Leaves time 5 ns past a rising edge.
	task automatic advance(input int cycles);
		repeat (cycles) @(posedge clock);
		#5;
	endtask

	task automatic check_value(input string signal_name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERROR: %s expected 0x%08h actual 0x%08h", signal_name, expected, actual);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic wait_spi_out_low();
		int cycles;
		cycles = 0;
		while (spi_out !== 1'b0)
		begin
			if (cycles == 16)
			begin
				$display("Timeout: spi_out did not return low with chip select high");
				$display("Regression failed");
				$fatal(1);
			end
			advance(1);
			cycles++;
		end
	endtask

	// Mode 0, MSB first, 8 system clocks per half period.
	task automatic transfer_byte(input logic [7:0] out_byte, output logic [7:0] in_byte);
		for (int index = 7; index >= 0; index--)
		begin
			spi_in = out_byte[index];
			advance(8);
			in_byte[index] = spi_out; // Sampled just before the rising edge.
			spi_clock = 1'b1;
			advance(8);
			spi_clock = 1'b0;
		end
	endtask

	task automatic select_device();
		spi_not_chip_select = 1'b0;
		advance(8);
	endtask

	// Hold covers the adder latency and the register write.
	task automatic release_device();
		advance(12);
		spi_not_chip_select = 1'b1;
		wait_spi_out_low();
		advance(8);
		check_value("spi_out", 32'd0, {31'd0, spi_out});
	endtask

	task automatic spi_write_register(input logic [1:0] id, input logic [31:0] value);
		logic [7:0] ignored;
		select_device();
		transfer_byte(8'h00, ignored);
		transfer_byte({6'd0, id}, ignored);
		for (int index = 0; index < 4; index++)
			transfer_byte(value[8 * index +: 8], ignored); // LSB first.
		release_device();
	endtask

	task automatic spi_read_register(input logic [1:0] id, output logic [31:0] value);
		logic [7:0] ignored;
		logic [7:0] data;
		select_device();
		transfer_byte(8'h02, ignored);
		transfer_byte({6'd0, id}, ignored);
		for (int index = 0; index < 4; index++)
		begin
			transfer_byte(8'h00, data);
			value[8 * index +: 8] = data;
		end
		release_device();
	endtask

	task automatic spi_add(input logic [1:0] id_a, input logic [1:0] id_b,
			input logic [1:0] target);
		logic [7:0] ignored;
		select_device();
		transfer_byte(8'h01, ignored);
		transfer_byte({6'd0, id_a}, ignored);
		transfer_byte({6'd0, id_b}, ignored);
		transfer_byte({6'd0, target}, ignored);
		release_device();
	endtask

	task automatic verify_registers();
		logic [31:0] word;
		for (int index = 0; index < 4; index++)
		begin
			spi_read_register(2'(index), word);
			check_value($sformatf("register %0d", index), model[index], word);
		end
	endtask

	// Exact for magnitudes below 2^24.
	function automatic logic [31:0] int_to_float(input int value);
		logic [31:0] magnitude;
		logic [31:0] bits;
		int          msb;
		if (value == 0)
			return 32'd0;
		magnitude = (value < 0) ? -value : value;
		msb = 0;
		for (int index = 0; index < 32; index++)
			if (magnitude[index])
				msb = index;
		bits[31]    = value < 0;
		bits[30:23] = 8'(127 + msb);
		bits[22:0]  = 23'(magnitude << (23 - msb));
		return bits;
	endfunction

	initial
	begin
		clock               = 1'b0;
		reset               = 1'b1;
		spi_clock           = 1'b0;
		spi_in              = 1'b0;
		spi_not_chip_select = 1'b1;
		seed                = 98169;
		advance(4);
		reset = 1'b0;
		advance(2);
		wait_spi_out_low();

		for (int index = 0; index < 4; index++)
			model[index] = 32'd0;
		verify_registers();

		for (int index = 0; index < 4; index++)
		begin
			pattern = $random(seed);
			spi_write_register(2'(index), pattern);
			model[index] = pattern;
		end
		verify_registers();

		// Exact integer sums, target reused as an operand.
		value_a = $random(seed) % 1000;
		value_b = $random(seed) % 1000;
		spi_write_register(2'd0, int_to_float(value_a));
		spi_write_register(2'd1, int_to_float(value_b));
		model[0] = int_to_float(value_a);
		model[1] = int_to_float(value_b);
		spi_add(2'd0, 2'd1, 2'd2);
		model[2] = int_to_float(value_a + value_b);
		spi_add(2'd2, 2'd0, 2'd2);
		model[2] = int_to_float(value_a + value_b + value_a);
		power = 1 << ($random(seed) & 15);
		if ($random(seed) & 1)
			power = -power;
		spi_write_register(2'd3, int_to_float(power));
		model[3] = int_to_float(power);
		spi_add(2'd3, 2'd1, 2'd3);
		model[3] = int_to_float(power + value_b);
		verify_registers();

		// Equal magnitude, opposite sign.
		value_a = $random(seed) % 1000;
		if (value_a == 0)
			value_a = 1;
		spi_write_register(2'd1, int_to_float(value_a));
		spi_write_register(2'd3, int_to_float(-value_a));
		model[1] = int_to_float(value_a);
		model[3] = int_to_float(-value_a);
		spi_add(2'd1, 2'd3, 2'd0);
		model[0] = 32'd0;
		verify_registers();

		// Wide exponent gap, then a denormal flushed to zero.
		spi_write_register(2'd0, int_to_float(1 << 20));
		spi_write_register(2'd1, int_to_float(1));
		model[0] = int_to_float(1 << 20);
		model[1] = int_to_float(1);
		spi_add(2'd0, 2'd1, 2'd2);
		model[2] = int_to_float((1 << 20) + 1);
		pattern = {9'd0, 23'($random(seed))};
		spi_write_register(2'd3, pattern);
		spi_write_register(2'd1, int_to_float(7));
		model[3] = pattern;
		model[1] = int_to_float(7);
		spi_add(2'd3, 2'd1, 2'd0);
		model[0] = int_to_float(7);
		verify_registers();

		// Reserved command with trailing bytes.
		select_device();
		transfer_byte(8'h03, received[7:0]);
		for (int index = 0; index < 5; index++)
			transfer_byte(8'($random(seed)), received[7:0]);
		release_device();
		verify_registers();

		// Write cut short after two data bytes.
		pattern = $random(seed);
		select_device();
		transfer_byte(8'h00, received[7:0]);
		transfer_byte(8'h01, received[7:0]);
		transfer_byte(pattern[7:0], received[7:0]);
		transfer_byte(pattern[15:8], received[7:0]);
		release_device();
		model[1][15:0] = pattern[15:0];
		verify_registers();
		pattern = $random(seed) | 32'h0000_0080;
		spi_write_register(2'd1, pattern);
		model[1] = pattern;

		// Read cut short while the first response bit is high.
		select_device();
		transfer_byte(8'h02, received[7:0]);
		transfer_byte(8'h01, received[7:0]);
		advance(8);
		check_value("spi_out", 32'd1, {31'd0, spi_out});
		release_device();
		verify_registers();

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/spi_fpu_pkg.sv
source/spi_link.sv
source/float_adder.sv
source/fpu_controller.sv
source/spi_fpu.sv
tb/spi_fpu_tb.sv

// ==== Bender.yml ====
package:
  name: spi_fpu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/spi_fpu_pkg.sv
      - source/spi_link.sv
      - source/float_adder.sv
      - source/fpu_controller.sv
      - source/spi_fpu.sv
  - target: test
    files:
      - tb/spi_fpu_tb.sv
